/* list.f */
rtl/mac_frame_pkg.sv
rtl/rcv_cfg_pkg.sv
rtl/frame_buffer.sv
rtl/crc8_accum.sv
rtl/frame_counters.sv
rtl/rcv_fsm.sv
rtl/frame_receiver.sv
bench/frame_receiver_checker.sv
bench/frame_receiver_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --top-module frame_receiver_tb \
    -f list.f -o frame_receiver_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/frame_receiver_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "^STATUS: PASS$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* bench/frame_receiver_tb.sv */
`timescale 1ns/1ps

module frame_receiver_tb;
    import mac_frame_pkg::*;
    import rcv_cfg_pkg::*;

    localparam byte_t MY_MAC      = 8'h5c;
    localparam byte_t OTHER_MAC   = 8'h71;
    localparam byte_t SRC_ADDR    = 8'h33;
    localparam ftype_t BAD_TYPE   = 8'h09;
    localparam int MAX_PAYLOAD    = 24;
    // header, payload and check byte
    localparam int MAX_FRAME      = TYPE_OFFSET + 1 + MAX_PAYLOAD + 1;
    localparam int SHORT_FRAMES   = 18;
    // runs past the end of the buffer
    localparam int LONG_LEN       = 2 ** BUF_ADDR_W + 8;
    localparam int STIM_BYTES     = SHORT_FRAMES * MAX_FRAME + LONG_LEN;
    localparam int CYCLE_LIMIT    = 40 * STIM_BYTES + 2000;
    // type decision and delivery start both fall well inside this
    localparam int SETTLE         = 8;

    logic    clk;
    logic    rst;
    logic    valid;
    logic    cardet;
    logic    rrdy;
    byte_t   data_rcvr;
    byte_t   mac;
    byte_t   rdata;
    logic    rvalid;
    logic    ack_needed;
    logic    ack_received;
    errcnt_t rerrcount;

    byte_t   frame_q[$];
    byte_t   exp_q[$];
    byte_t   exp_b;
    errcnt_t exp_err;
    string   test_name;
    int      errors;
    int      ackn_seen;
    int      ackr_seen;
    int      cycles;

    frame_receiver #(
        .ADDR_W (BUF_ADDR_W)
    ) uut (
        .clk          (clk),
        .rst          (rst),
        .valid        (valid),
        .cardet       (cardet),
        .rrdy         (rrdy),
        .data_rcvr    (data_rcvr),
        .mac          (mac),
        .rdata        (rdata),
        .rvalid       (rvalid),
        .ack_needed   (ack_needed),
        .ack_received (ack_received),
        .rerrcount    (rerrcount)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // consumer ready about 70% of the time
    always @(posedge clk) begin
        rrdy <= ($urandom_range(0, 9) < 7);
    end

    // bit-serial CRC-8 over the first count bytes of the frame
    function automatic byte_t frame_crc(int count);
        byte_t c;
        logic  fb;
        c = '0;
        for (int n = 0; n < count; n++) begin
            for (int i = 7; i >= 0; i--) begin
                fb = c[7] ^ frame_q[n][i];
                c = {c[6:0], 1'b0};
                if (fb) begin
                    c = c ^ CRC_POLY;
                end
            end
        end
        return c;
    endfunction

    task automatic build_frame(input byte_t dest, input ftype_t ftype, input bit corrupt);
        int    plen;
        byte_t fcs;
        plen = $urandom_range(1, MAX_PAYLOAD);
        frame_q.delete();
        frame_q.push_back(dest);
        frame_q.push_back(SRC_ADDR);
        frame_q.push_back(ftype);
        repeat (plen) begin
            frame_q.push_back(byte_t'($urandom()));
        end
        fcs = frame_crc(frame_q.size());
        // one flipped bit leaves a nonzero remainder
        if (corrupt) begin
            fcs = fcs ^ 8'h10;
        end
        frame_q.push_back(fcs);
    endtask

    task automatic build_long_frame();
        frame_q.delete();
        frame_q.push_back(MY_MAC);
        frame_q.push_back(SRC_ADDR);
        frame_q.push_back(FTYPE_DATA);
        while (frame_q.size() < LONG_LEN) begin
            frame_q.push_back(byte_t'($urandom()));
        end
    endtask

    // carrier up, one valid pulse per byte with a gap, carrier down
    task automatic send_frame();
        @(posedge clk);
        cardet <= 1'b1;
        foreach (frame_q[i]) begin
            @(posedge clk);
            valid     <= 1'b1;
            data_rcvr <= frame_q[i];
            @(posedge clk);
            valid     <= 1'b0;
        end
        @(posedge clk);
        cardet <= 1'b0;
    endtask

    task automatic run_frame(input string name, input bit deliver, input int ackn,
                             input int ackr, input bit err);
        test_name = name;
        ackn_seen = 0;
        ackr_seen = 0;
        // delivered bytes are the frame minus its check byte
        if (deliver) begin
            for (int i = 0; i < frame_q.size() - 1; i++) begin
                exp_q.push_back(frame_q[i]);
            end
        end
        if (err) begin
            exp_err = exp_err + 8'd1;
        end
        send_frame();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (SETTLE) @(posedge clk);
        @(negedge clk);
        assert (ackn_seen == ackn) else begin
            $display("%s: ack_needed pulsed %0d times, wanted %0d", name, ackn_seen, ackn);
            errors++;
        end
        assert (ackr_seen == ackr) else begin
            $display("%s: ack_received pulsed %0d times, wanted %0d", name, ackr_seen, ackr);
            errors++;
        end
        assert (rerrcount == exp_err) else begin
            $display("ERR %s: rerrcount expected %0d actual %0d", name, exp_err, rerrcount);
            errors++;
        end
    endtask

    // outputs sampled half a cycle after the edge that set them
    always @(negedge clk) begin
        if (!rst) begin
            if (rvalid && rrdy) begin
                assert (exp_q.size() != 0) else begin
                    $display("%s: byte %h delivered when none was due", test_name, rdata);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    exp_b = exp_q.pop_front();
                    assert (rdata == exp_b) else begin
                        $display("ERR %s: rdata expected %h actual %h", test_name, exp_b, rdata);
                        errors++;
                    end
                end
            end
            if (ack_needed) begin
                ackn_seen++;
            end
            if (ack_received) begin
                ackr_seen++;
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles during %s, the receiver stopped responding",
                 cycles, test_name);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(47));
        rst       = 1'b1;
        valid     = 1'b0;
        cardet    = 1'b0;
        rrdy      = 1'b0;
        data_rcvr = '0;
        mac       = MY_MAC;
        errors    = 0;
        exp_err   = '0;
        test_name = "reset";
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);

        for (int i = 0; i < 6; i++) begin
            build_frame(MY_MAC, FTYPE_DATA, 1'b0);
            run_frame("type1_to_mac", 1'b1, 0, 0, 1'b0);
        end

        build_frame(OTHER_MAC, FTYPE_DATA, 1'b0);
        run_frame("other_station", 1'b0, 0, 0, 1'b0);
        build_frame(BCAST_ADDR, FTYPE_DATA, 1'b0);
        run_frame("broadcast", 1'b1, 0, 0, 1'b0);

        build_frame(MY_MAC, FTYPE_DATA, 1'b1);
        run_frame("type1_bad_fcs", 1'b0, 0, 0, 1'b1);
        build_frame(MY_MAC, FTYPE_DATA_ACK, 1'b1);
        run_frame("type2_bad_fcs", 1'b0, 0, 0, 1'b1);
        build_frame(MY_MAC, FTYPE_RAW, 1'b1);
        run_frame("type0_bad_fcs", 1'b1, 0, 0, 1'b0);

        build_frame(MY_MAC, FTYPE_DATA_ACK, 1'b0);
        run_frame("type2_to_mac", 1'b1, 1, 0, 1'b0);
        build_frame(BCAST_ADDR, FTYPE_DATA_ACK, 1'b0);
        run_frame("type2_broadcast", 1'b1, 0, 0, 1'b0);

        build_frame(MY_MAC, FTYPE_ACK, 1'b0);
        run_frame("type3_good", 1'b0, 0, 1, 1'b0);
        build_frame(MY_MAC, FTYPE_ACK, 1'b1);
        run_frame("type3_bad_fcs", 1'b0, 0, 0, 1'b1);

        build_long_frame();
        run_frame("overflow", 1'b0, 0, 0, 1'b1);
        build_frame(MY_MAC, FTYPE_DATA, 1'b0);
        run_frame("after_overflow", 1'b1, 0, 0, 1'b0);
        build_frame(MY_MAC, BAD_TYPE, 1'b0);
        run_frame("unknown_type", 1'b0, 0, 0, 1'b1);
        build_frame(MY_MAC, FTYPE_DATA, 1'b0);
        run_frame("after_unknown", 1'b1, 0, 0, 1'b0);

        @(negedge clk);
        $display("check errors: %0d, checker assertion failures: %0d",
                 errors, uut.chk.fail_cnt);
        if (errors == 0 && uut.chk.fail_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* bench/frame_receiver_checker.sv */
`timescale 1ns/1ps

module frame_receiver_checker (
    input logic                 clk,
    input logic                 rst,
    input logic                 rrdy,
    input logic                 rvalid,
    input mac_frame_pkg::byte_t rdata,
    input logic                 ack_needed,
    input logic                 ack_received,
    input rcv_cfg_pkg::errcnt_t rerrcount
);
    // count of failed assertions
    int fail_cnt = 0;

    // a stalled output byte stays put until taken
    hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rrdy |=> rvalid && $stable(rdata))
        else begin
            $error("rvalid or rdata changed while rrdy was low");
            fail_cnt++;
        end

    ack_needed_pulse: assert property (@(posedge clk) disable iff (rst)
        ack_needed |=> !ack_needed)
        else begin
            $error("ack_needed stayed high for more than one cycle");
            fail_cnt++;
        end

    ack_received_pulse: assert property (@(posedge clk) disable iff (rst)
        ack_received |=> !ack_received)
        else begin
            $error("ack_received stayed high for more than one cycle");
            fail_cnt++;
        end

    acks_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(ack_needed && ack_received))
        else begin
            $error("ack_needed and ack_received high in the same cycle");
            fail_cnt++;
        end

    // count only moves up once out of reset
    errcount_monotonic: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> rerrcount >= $past(rerrcount))
        else begin
            $error("rerrcount decreased");
            fail_cnt++;
        end

    rvalid_in_reset: assert property (@(posedge clk)
        rst |=> !rvalid)
        else begin
            $error("rvalid high while in reset");
            fail_cnt++;
        end

endmodule

bind frame_receiver frame_receiver_checker chk (
    .clk          (clk),
    .rst          (rst),
    .rrdy         (rrdy),
    .rvalid       (rvalid),
    .rdata        (rdata),
    .ack_needed   (ack_needed),
    .ack_received (ack_received),
    .rerrcount    (rerrcount)
);

/* rtl/frame_receiver.sv */
`timescale 1ns/1ps

module frame_receiver #(
    parameter int ADDR_W = $bits(rcv_cfg_pkg::buf_addr_t)
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 valid,
    input  logic                 cardet,
    input  logic                 rrdy,
    input  mac_frame_pkg::byte_t data_rcvr,
    input  mac_frame_pkg::byte_t mac,
    output mac_frame_pkg::byte_t rdata,
    output logic                 rvalid,
    output logic                 ack_needed,
    output logic                 ack_received,
    output rcv_cfg_pkg::errcnt_t rerrcount
);
    import mac_frame_pkg::*;

    // RAM read data, one cycle behind rd_addr
    byte_t data_bram;

    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;

    // controller strobes
    logic write_en;
    logic wr_clr;
    logic crc_clr;
    logic crc_enb;
    logic rd_step;
    logic rd_clr;
    logic rd_load_type;
    logic err_inc;

    // status back to the controller
    logic crc_zero;
    logic wr_full;
    logic rd_last;

    rcv_fsm #(
        .ADDR_W (ADDR_W)
    ) u_fsm (
        .clk          (clk),
        .rst          (rst),
        .valid        (valid),
        .cardet       (cardet),
        .rrdy         (rrdy),
        .data_rcvr    (data_rcvr),
        .mac          (mac),
        .data_bram    (data_bram),
        .crc_zero     (crc_zero),
        .wr_full      (wr_full),
        .rd_last      (rd_last),
        .write_en     (write_en),
        .wr_clr       (wr_clr),
        .crc_clr      (crc_clr),
        .crc_enb      (crc_enb),
        .rd_step      (rd_step),
        .rd_clr       (rd_clr),
        .rd_load_type (rd_load_type),
        .err_inc      (err_inc),
        .rvalid       (rvalid),
        .ack_needed   (ack_needed),
        .ack_received (ack_received)
    );

    frame_counters #(
        .ADDR_W (ADDR_W)
    ) u_counters (
        .clk          (clk),
        .rst          (rst),
        .wr_step      (write_en),
        .wr_clr       (wr_clr),
        .rd_step      (rd_step),
        .rd_clr       (rd_clr),
        .rd_load_type (rd_load_type),
        .err_inc      (err_inc),
        .wr_addr      (wr_addr),
        .rd_addr      (rd_addr),
        .wr_full      (wr_full),
        .rd_last      (rd_last),
        .rerrcount    (rerrcount)
    );

    frame_buffer #(
        .ADDR_W (ADDR_W)
    ) u_buffer (
        .clk   (clk),
        .we    (write_en),
        .waddr (wr_addr),
        .wdata (data_rcvr),
        .raddr (rd_addr),
        .rdata (data_bram)
    );

    crc8_accum u_crc (
        .clk      (clk),
        .rst      (rst),
        .clr      (crc_clr),
        .enb      (crc_enb),
        .din      (data_rcvr),
        .crc_zero (crc_zero)
    );

    // prefetched byte moves to the output on each read step
    always_ff @(posedge clk) begin
        if (rd_step) begin
            rdata <= data_bram;
        end
    end

endmodule

/* rtl/rcv_fsm.sv */
`timescale 1ns/1ps

module rcv_fsm #(
    parameter int ADDR_W = $bits(rcv_cfg_pkg::buf_addr_t)
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 valid,
    input  logic                 cardet,
    input  logic                 rrdy,
    input  mac_frame_pkg::byte_t data_rcvr,
    input  mac_frame_pkg::byte_t mac,
    input  mac_frame_pkg::byte_t data_bram,
    input  logic                 crc_zero,
    input  logic                 wr_full,
    input  logic                 rd_last,
    output logic                 write_en,
    output logic                 wr_clr,
    output logic                 crc_clr,
    output logic                 crc_enb,
    output logic                 rd_step,
    output logic                 rd_clr,
    output logic                 rd_load_type,
    output logic                 err_inc,
    output logic                 rvalid,
    output logic                 ack_needed,
    output logic                 ack_received
);
    import mac_frame_pkg::*;
    import rcv_cfg_pkg::*;

    // smallest frame is the header plus the check byte
    if ((2 ** ADDR_W) - 1 < TYPE_OFFSET + 1 + FCS_LEN) begin : g_addr_w_chk
        $error("buffer too small to hold a frame header");
    end

    rcv_state_t state;
    rcv_state_t next;

    logic addr_hit;
    // frame was sent to the broadcast address
    logic bcast;
    // read address moved last cycle, data_bram is stale
    logic pend;
    // last payload byte already in the output register
    logic tail;
    logic xfer;
    logic deliver;

    assign addr_hit = (data_rcvr == mac) || (data_rcvr == BCAST_ADDR);
    assign xfer     = rvalid && rrdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            bcast  <= 1'b0;
            pend   <= 1'b0;
            tail   <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            state <= next;
            pend  <= rd_step | rd_clr;

            // destination byte decides ack handling later on
            if (state == IDLE && write_en) begin
                bcast <= (data_rcvr == BCAST_ADDR);
            end

            if (rd_clr) begin
                tail <= 1'b0;
            end else if (rd_step && rd_last) begin
                tail <= 1'b1;
            end

            // output byte valid from load until taken
            if (rd_step) begin
                rvalid <= 1'b1;
            end else if (xfer) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_comb begin
        next         = state;
        write_en     = 1'b0;
        wr_clr       = 1'b0;
        crc_clr      = 1'b0;
        crc_enb      = 1'b0;
        rd_step      = 1'b0;
        rd_clr       = 1'b0;
        rd_load_type = 1'b0;
        err_inc      = 1'b0;
        ack_needed   = 1'b0;
        ack_received = 1'b0;
        deliver      = 1'b0;

        case (state)
            IDLE: begin
                crc_clr = 1'b1;
                if (valid && cardet) begin
                    if (addr_hit) begin
                        write_en = 1'b1;
                        crc_enb  = 1'b1;
                        next     = WRITE;
                    end else begin
                        // not for us, sit out the carrier
                        next = DROP;
                    end
                end
            end

            WRITE: begin
                if (!cardet) begin
                    rd_load_type = 1'b1;
                    next         = FETCH_TYPE;
                end else if (valid) begin
                    if (wr_full) begin
                        err_inc = 1'b1;
                        next    = DROP;
                    end else begin
                        write_en = 1'b1;
                        crc_enb  = 1'b1;
                    end
                end
            end

            // type byte address is on the RAM this cycle
            FETCH_TYPE: begin
                next = CHECK_TYPE;
            end

            CHECK_TYPE: begin
                case (data_bram)
                    FTYPE_RAW: begin
                        deliver = 1'b1;
                    end
                    FTYPE_DATA: begin
                        deliver = crc_zero;
                        err_inc = !crc_zero;
                    end
                    FTYPE_DATA_ACK: begin
                        deliver    = crc_zero;
                        err_inc    = !crc_zero;
                        ack_needed = crc_zero && !bcast;
                    end
                    FTYPE_ACK: begin
                        // acks are consumed here, never delivered
                        ack_received = crc_zero;
                        err_inc      = !crc_zero;
                    end
                    default: begin
                        err_inc = 1'b1;
                    end
                endcase

                if (deliver) begin
                    rd_clr = 1'b1;
                    next   = DELIVER;
                end else begin
                    wr_clr = 1'b1;
                    next   = cardet ? DROP : IDLE;
                end
            end

            DELIVER: begin
                // load the next byte once the RAM output is fresh and the register is free
                rd_step = !pend && !tail && (!rvalid || rrdy);
                if (tail && xfer) begin
                    wr_clr = 1'b1;
                    next   = cardet ? DROP : IDLE;
                end
            end

            DROP: begin
                wr_clr = 1'b1;
                if (!cardet) begin
                    next = IDLE;
                end
            end

            default: begin
                next = IDLE;
            end
        endcase
    end

endmodule

/* rtl/frame_counters.sv */
`timescale 1ns/1ps

module frame_counters #(
    parameter int ADDR_W = $bits(rcv_cfg_pkg::buf_addr_t)
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_step,
    input  logic                  wr_clr,
    input  logic                  rd_step,
    input  logic                  rd_clr,
    input  logic                  rd_load_type,
    input  logic                  err_inc,
    output logic [ADDR_W-1:0]     wr_addr,
    output logic [ADDR_W-1:0]     rd_addr,
    output logic                  wr_full,
    output logic                  rd_last,
    output rcv_cfg_pkg::errcnt_t  rerrcount
);
    import mac_frame_pkg::*;

    // write pointer, equal to the stored frame length
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_addr <= '0;
        end else if (wr_clr) begin
            wr_addr <= '0;
        end else if (wr_step) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

    // read pointer
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_addr <= '0;
        end else if (rd_clr) begin
            rd_addr <= '0;
        end else if (rd_load_type) begin
            // jump straight to the type byte
            rd_addr <= ADDR_W'(TYPE_OFFSET);
        end else if (rd_step) begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    // error count, sticks at 255
    always_ff @(posedge clk) begin
        if (rst) begin
            rerrcount <= '0;
        end else if (err_inc && (rerrcount != '1)) begin
            rerrcount <= rerrcount + 1'b1;
        end
    end

    // a byte arriving here would not fit, so the frame overflows
    assign wr_full = (wr_addr == '1);

    // last payload byte sits just ahead of the check byte
    assign rd_last = (rd_addr == wr_addr - ADDR_W'(FCS_LEN + 1));

endmodule

/* rtl/crc8_accum.sv */
`timescale 1ns/1ps

module crc8_accum (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 clr,
    input  logic                 enb,
    input  mac_frame_pkg::byte_t din,
    output logic                 crc_zero
);
    import mac_frame_pkg::*;

    byte_t crc;
    byte_t seed;

    // one byte through the CRC-8 shift register, MSB first
    function automatic byte_t crc8_step(byte_t c_in, byte_t d);
        byte_t c;
        c = c_in ^ d;
        for (int i = 0; i < 8; i++) begin
            if (c[7]) begin
                c = (c << 1) ^ CRC_POLY;
            end else begin
                c = c << 1;
            end
        end
        return c;
    endfunction

    // clear and enable together start a new frame with this byte
    assign seed = clr ? '0 : crc;

    always_ff @(posedge clk) begin
        if (rst) begin
            crc <= '0;
        end else if (enb) begin
            crc <= crc8_step(seed, din);
        end else if (clr) begin
            crc <= '0;
        end
    end

    assign crc_zero = (crc == '0);

endmodule

/* rtl/frame_buffer.sv */
`timescale 1ns/1ps

module frame_buffer #(
    parameter int ADDR_W = $bits(rcv_cfg_pkg::buf_addr_t)
) (
    input  logic                 clk,
    input  logic                 we,
    input  logic [ADDR_W-1:0]    waddr,
    input  mac_frame_pkg::byte_t wdata,
    input  logic [ADDR_W-1:0]    raddr,
    output mac_frame_pkg::byte_t rdata
);
    import mac_frame_pkg::*;

    localparam int DEPTH = 2 ** ADDR_W;

    // frame storage, one byte per address
    byte_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, data one cycle after the address
    // same address read and write returns the old byte
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

/* rtl/rcv_cfg_pkg.sv */
package rcv_cfg_pkg;

    // default buffer address width, 512 bytes
    localparam int BUF_ADDR_W = 9;

    // buffer address at the default width
    // ADDR_W of the modules defaults to the width of this type
    typedef logic [BUF_ADDR_W-1:0] buf_addr_t;

    // receive error count
    typedef logic [7:0] errcnt_t;

    // receive controller states
    typedef enum logic [2:0] {
        IDLE,
        WRITE,
        FETCH_TYPE,
        CHECK_TYPE,
        DELIVER,
        DROP
    } rcv_state_t;

endpackage

/* rtl/mac_frame_pkg.sv */
package mac_frame_pkg;

    // one byte as it comes from the demodulator
    typedef logic [7:0] byte_t;

    // frame type field
    typedef logic [7:0] ftype_t;

    // frame type codes
    localparam ftype_t FTYPE_RAW      = 8'd0;
    localparam ftype_t FTYPE_DATA     = 8'd1;
    localparam ftype_t FTYPE_DATA_ACK = 8'd2;
    localparam ftype_t FTYPE_ACK      = 8'd3;

    // destination address accepted by every station
    localparam byte_t BCAST_ADDR = 8'h2a;

    // frame layout is dest, src, type, payload, check byte
    localparam int TYPE_OFFSET = 2;

    // trailing check byte count
    localparam int FCS_LEN = 1;

    // CRC-8, init 0, MSB first
    // a good frame leaves a zero remainder over all bytes incl. the check byte
    localparam byte_t CRC_POLY = 8'h07;

endpackage
